// ==== design/pc_chain_check.sv ====
module pc_chain_check #(
	parameter int XLEN = 32
) (
	input  logic			clk,
	input  logic			rst_n,
	input  logic			rvfi_valid,
	input  logic [XLEN-1:0]	rvfi_pc_rdata,	// address of the retired instruction
	input  logic [XLEN-1:0]	rvfi_pc_wdata,	// address of the next instruction
	output logic			pc_err
);

	logic [XLEN-1:0]	next_pc;		// pc_wdata of the last retirement
	logic				have_pc;		// next_pc holds a real value
	logic				chain_break;

	// compare against the stored value, before this retirement updates it
	assign chain_break = have_pc && (rvfi_pc_rdata != next_pc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			have_pc	<= 1'b0;
			pc_err	<= 1'b0;
		end else begin
			pc_err <= rvfi_valid && chain_break;
			if (rvfi_valid)
				have_pc <= 1'b1;
		end
	end

	// every retirement moves the chain on, broken or not
	always_ff @(posedge clk) begin
		if (rvfi_valid)
			next_pc <= rvfi_pc_wdata;
	end

	// error pulse must trace back to a retirement one cycle earlier
	a_pc_err_after_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc_err |-> $past(rvfi_valid)
	) else $error("pc_err without a retirement in the previous cycle");

endmodule : pc_chain_check

// ==== design/reg_shadow_check.sv ====
module reg_shadow_check import rvfi_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic				clk,
	input  logic				rst_n,
	input  logic				rvfi_valid,
	input  logic [REG_AW-1:0]	rvfi_rs1_addr,
	input  logic [REG_AW-1:0]	rvfi_rs2_addr,
	input  logic [XLEN-1:0]		rvfi_rs1_rdata,	// value of rs1 before the instruction
	input  logic [XLEN-1:0]		rvfi_rs2_rdata,
	input  logic [REG_AW-1:0]	rvfi_rd_addr,
	input  logic [XLEN-1:0]		rvfi_rd_wdata,	// value of rd after the instruction
	output logic				reg_err,
	output logic				x0_err
);

	localparam int NREG = 1 << REG_AW;

	logic [XLEN-1:0]	shadow [NREG];	// last value written per register
	logic [NREG-1:0]	known;			// register written since reset
	logic				rs1_bad;
	logic				rs2_bad;
	logic				rd_is_x0;

	// x0 is always known and reads as zero
	function automatic logic read_bad(
		input logic [REG_AW-1:0]	addr,
		input logic [XLEN-1:0]		data,
		input logic					is_known,
		input logic [XLEN-1:0]		expect_val
	);
		if (addr == '0)
			return data != '0;
		else if (is_known)
			return data != expect_val;
		else
			return 1'b0;			// never written, nothing to compare
	endfunction

	assign rs1_bad = read_bad(rvfi_rs1_addr, rvfi_rs1_rdata,
		known[rvfi_rs1_addr], shadow[rvfi_rs1_addr]);
	assign rs2_bad = read_bad(rvfi_rs2_addr, rvfi_rs2_rdata,
		known[rvfi_rs2_addr], shadow[rvfi_rs2_addr]);
	assign rd_is_x0 = (rvfi_rd_addr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			known	<= '0;
			reg_err	<= 1'b0;
			x0_err	<= 1'b0;
		end else begin
			reg_err	<= rvfi_valid && (rs1_bad || rs2_bad);	// one pulse per instruction
			x0_err	<= rvfi_valid && rd_is_x0 && (rvfi_rd_wdata != '0);
			if (rvfi_valid && !rd_is_x0)
				known[rvfi_rd_addr] <= 1'b1;
		end
	end

	// writes to x0 are dropped, the reads above see the old values
	always_ff @(posedge clk) begin
		if (rvfi_valid && !rd_is_x0)
			shadow[rvfi_rd_addr] <= rvfi_rd_wdata;
	end

	// x0 stays hardwired regardless of what retires
	a_x0_never_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!known[0]
	) else $error("known bit of x0 set");

endmodule : reg_shadow_check

// ==== design/retire_order_check.sv ====
module retire_order_check import rvfi_pkg::*; (
	input  logic				clk,
	input  logic				rst_n,
	input  logic				rvfi_valid,
	input  logic [ORDER_W-1:0]	rvfi_order,
	input  logic				rvfi_halt,
	output logic				order_err,
	output logic				halt_err
);

	order_state_t			state;
	logic [ORDER_W-1:0]		last_order;		// order of previous retirement

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state		<= ST_IDLE;
			order_err	<= 1'b0;
			halt_err	<= 1'b0;
		end else begin
			order_err	<= 1'b0;		// pulses, one cycle only
			halt_err	<= 1'b0;
			if (rvfi_valid) begin
				case (state)
					ST_IDLE: begin
						// first retirement sets the baseline, any order accepted
						state <= rvfi_halt ? ST_HALTED : ST_RUN;
					end
					ST_RUN: begin
						order_err <= (rvfi_order != last_order + 1'b1);
						if (rvfi_halt)
							state <= ST_HALTED;
					end
					ST_HALTED: begin
						halt_err <= 1'b1;	// nothing else checked once halted
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// baseline for the next order check
	always_ff @(posedge clk) begin
		if (rvfi_valid)
			last_order <= rvfi_order;
	end

	// a halted checker reports only halt errors
	a_order_halt_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(order_err && halt_err)
	) else $error("order_err and halt_err high together");

endmodule : retire_order_check

// ==== design/rvfi_monitor.sv ====
module rvfi_monitor import rvfi_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic				clk,
	input  logic				rst_n,

	// retirement port, one instruction per cycle at most
	input  logic				rvfi_valid,
	input  logic [ORDER_W-1:0]	rvfi_order,
	input  logic				rvfi_halt,
	input  logic [XLEN-1:0]		rvfi_pc_rdata,
	input  logic [XLEN-1:0]		rvfi_pc_wdata,
	input  logic [REG_AW-1:0]	rvfi_rs1_addr,
	input  logic [REG_AW-1:0]	rvfi_rs2_addr,
	input  logic [XLEN-1:0]		rvfi_rs1_rdata,
	input  logic [XLEN-1:0]		rvfi_rs2_rdata,
	input  logic [REG_AW-1:0]	rvfi_rd_addr,
	input  logic [XLEN-1:0]		rvfi_rd_wdata,

	// results, two cycles behind the retirement
	output logic [CNT_W-1:0]	error_count,
	output violation_code_t		first_code,
	output logic				error_seen
);

	logic	order_err;
	logic	halt_err;
	logic	pc_err;
	logic	reg_err;
	logic	x0_err;

	retire_order_check retire_order_check_inst (
		.clk			(clk),
		.rst_n			(rst_n),
		.rvfi_valid		(rvfi_valid),
		.rvfi_order		(rvfi_order),
		.rvfi_halt		(rvfi_halt),
		.order_err		(order_err),
		.halt_err		(halt_err)
	);

	pc_chain_check #(
		.XLEN			(XLEN)
	) pc_chain_check_inst (
		.clk			(clk),
		.rst_n			(rst_n),
		.rvfi_valid		(rvfi_valid),
		.rvfi_pc_rdata	(rvfi_pc_rdata),
		.rvfi_pc_wdata	(rvfi_pc_wdata),
		.pc_err			(pc_err)
	);

	reg_shadow_check #(
		.XLEN			(XLEN)
	) reg_shadow_check_inst (
		.clk			(clk),
		.rst_n			(rst_n),
		.rvfi_valid		(rvfi_valid),
		.rvfi_rs1_addr	(rvfi_rs1_addr),
		.rvfi_rs2_addr	(rvfi_rs2_addr),
		.rvfi_rs1_rdata	(rvfi_rs1_rdata),
		.rvfi_rs2_rdata	(rvfi_rs2_rdata),
		.rvfi_rd_addr	(rvfi_rd_addr),
		.rvfi_rd_wdata	(rvfi_rd_wdata),
		.reg_err		(reg_err),
		.x0_err			(x0_err)
	);

	violation_log violation_log_inst (
		.clk			(clk),
		.rst_n			(rst_n),
		.order_err		(order_err),
		.halt_err		(halt_err),
		.pc_err			(pc_err),
		.reg_err		(reg_err),
		.x0_err			(x0_err),
		.error_count	(error_count),
		.first_code		(first_code),
		.error_seen		(error_seen)
	);

endmodule : rvfi_monitor

// ==== design/rvfi_pkg.sv ====
package rvfi_pkg;

	// RVFI retirement port widths, NRET fixed at 1
	localparam int ORDER_W = 64;	// instruction order number
	localparam int REG_AW  = 5;		// register address, 32 integer registers
	localparam int CNT_W   = 8;		// violation counter, saturating

	// violation classes, VIOL_NONE until the first error arrives
	typedef enum logic [2:0] {
		VIOL_NONE		= 3'd0,
		VIOL_ORDER		= 3'd1,	// order number did not step by one
		VIOL_AFTER_HALT	= 3'd2,	// retirement after a halt
		VIOL_PC			= 3'd3,	// pc does not continue previous next pc
		VIOL_REG		= 3'd4,	// source read disagrees with shadow
		VIOL_X0			= 3'd5	// nonzero write to x0
	} violation_code_t;

	// order checker FSM
	typedef enum logic [1:0] {
		ST_IDLE		= 2'd0,	// nothing retired since reset
		ST_RUN		= 2'd1,
		ST_HALTED	= 2'd2
	} order_state_t;

endpackage : rvfi_pkg

// ==== design/violation_log.sv ====
module violation_log import rvfi_pkg::*; (
	input  logic				clk,
	input  logic				rst_n,
	input  logic				order_err,
	input  logic				halt_err,
	input  logic				pc_err,
	input  logic				reg_err,
	input  logic				x0_err,
	output logic [CNT_W-1:0]	error_count,
	output violation_code_t		first_code,
	output logic				error_seen
);

	logic [2:0]			n_pulse;		// pulses high this cycle, 0 to 5
	logic [CNT_W:0]		sum;			// one extra bit to catch overflow
	logic				any_err;
	violation_code_t	code_next;

	assign n_pulse	= {2'b00, order_err} + {2'b00, halt_err} + {2'b00, pc_err}
					+ {2'b00, reg_err} + {2'b00, x0_err};
	assign sum		= {1'b0, error_count} + {{(CNT_W - 2){1'b0}}, n_pulse};
	assign any_err	= (n_pulse != 3'd0);

	// priority when several checkers fire together
	always_comb begin
		if (order_err)
			code_next = VIOL_ORDER;
		else if (halt_err)
			code_next = VIOL_AFTER_HALT;
		else if (pc_err)
			code_next = VIOL_PC;
		else if (reg_err)
			code_next = VIOL_REG;
		else if (x0_err)
			code_next = VIOL_X0;
		else
			code_next = VIOL_NONE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			error_count	<= '0;
			first_code	<= VIOL_NONE;
			error_seen	<= 1'b0;
		end else begin
			if (sum[CNT_W])
				error_count <= '1;			// saturate
			else
				error_count <= sum[CNT_W-1:0];
			if (any_err && !error_seen)
				first_code <= code_next;	// only the first error is classified
			if (any_err)
				error_seen <= 1'b1;
		end
	end

	// count is monotonic between resets
	a_count_monotonic: assert property (
		@(posedge clk) disable iff (!rst_n)
		error_count >= $past(error_count)
	) else $error("error_count decreased");

endmodule : violation_log

// ==== dv/rvfi_stim_table.svh ====
`ifndef RVFI_STIM_TABLE_SVH
`define RVFI_STIM_TABLE_SVH

// one retirement per entry, or a reset, with the monitor outputs expected afterwards
typedef struct packed {
	logic					do_reset;	// entry is a reset, not a retirement
	logic [ORDER_W-1:0]		order;
	logic					halt;
	logic [XLEN-1:0]		pc_rdata;
	logic [XLEN-1:0]		pc_wdata;
	logic [REG_AW-1:0]		rs1_addr;
	logic [XLEN-1:0]		rs1_rdata;
	logic [REG_AW-1:0]		rs2_addr;
	logic [XLEN-1:0]		rs2_rdata;
	logic [REG_AW-1:0]		rd_addr;
	logic [XLEN-1:0]		rd_wdata;
	logic [CNT_W-1:0]		exp_count;
	violation_code_t		exp_code;
} stim_entry_t;

stim_entry_t stim_table [$];

task automatic add_retire(
	input logic [ORDER_W-1:0]	order,
	input logic					halt,
	input logic [XLEN-1:0]		pc_rdata,
	input logic [XLEN-1:0]		pc_wdata,
	input logic [REG_AW-1:0]	rs1_addr,
	input logic [XLEN-1:0]		rs1_rdata,
	input logic [REG_AW-1:0]	rs2_addr,
	input logic [XLEN-1:0]		rs2_rdata,
	input logic [REG_AW-1:0]	rd_addr,
	input logic [XLEN-1:0]		rd_wdata,
	input logic [CNT_W-1:0]		exp_count,
	input violation_code_t		exp_code
);
	stim_entry_t e;
	e = '0;
	e.order		= order;
	e.halt		= halt;
	e.pc_rdata	= pc_rdata;
	e.pc_wdata	= pc_wdata;
	e.rs1_addr	= rs1_addr;
	e.rs1_rdata	= rs1_rdata;
	e.rs2_addr	= rs2_addr;
	e.rs2_rdata	= rs2_rdata;
	e.rd_addr	= rd_addr;
	e.rd_wdata	= rd_wdata;
	e.exp_count	= exp_count;
	e.exp_code	= exp_code;
	stim_table.push_back(e);
endtask

task automatic add_reset();
	stim_entry_t e;
	e = '0;
	e.do_reset	= 1'b1;
	e.exp_code	= VIOL_NONE;	// reset values
	stim_table.push_back(e);
endtask

task automatic fill_table();
	// order, halt, pc_rdata, pc_wdata, rs1, rs1_data, rs2, rs2_data, rd, rd_data, count, code
	add_retire(100, 0, 'h1000, 'h1004, 0, 'h0, 0, 'h0, 1, 'h11, 0, VIOL_NONE);
	add_retire(101, 0, 'h1004, 'h1008, 1, 'h11, 0, 'h0, 2, 'h22, 0, VIOL_NONE);
	add_retire(102, 0, 'h1008, 'h100c, 2, 'h22, 1, 'h11, 3, 'h33, 0, VIOL_NONE);
	add_retire(103, 0, 'h100c, 'h1010, 3, 'h33, 2, 'h22, 4, 'h44, 0, VIOL_NONE);
	add_retire(104, 0, 'h1010, 'h1040, 4, 'h44, 1, 'h11, 0, 'h0, 0, VIOL_NONE);	// taken branch
	add_retire(105, 0, 'h1040, 'h1044, 1, 'h11, 3, 'h33, 5, 'hdeadbeef, 0, VIOL_NONE);
	add_retire(106, 0, 'h1044, 'h1048, 5, 'hdeadbeef, 4, 'h44, 1, 'h55, 0, VIOL_NONE);
	add_retire(107, 0, 'h1048, 'h104c, 1, 'h55, 5, 'hdeadbeef, 6, 'h66, 0, VIOL_NONE);
	add_retire(108, 0, 'h104c, 'h1050, 6, 'h66, 2, 'h22, 7, 'h77, 0, VIOL_NONE);
	add_retire(109, 0, 'h1050, 'h1054, 7, 'h77, 3, 'h33, 8, 'h88, 0, VIOL_NONE);
	add_retire(111, 0, 'h1054, 'h1058, 8, 'h88, 0, 'h0, 9, 'h99, 1, VIOL_ORDER);	// 110 skipped
	add_retire(112, 0, 'h2000, 'h2004, 9, 'h99, 0, 'h0, 0, 'h0, 2, VIOL_ORDER);	// pc break
	add_retire(113, 0, 'h2004, 'h2008, 1, 'h12345678, 2, 'h22, 10, 'ha0, 3, VIOL_ORDER);
	add_retire(114, 0, 'h2008, 'h200c, 20, 'hcafef00d, 21, 'h5a5a, 11, 'hb0, 3, VIOL_ORDER);
	add_retire(115, 0, 'h200c, 'h2010, 3, 'h0, 4, 'h1, 0, 'h0, 4, VIOL_ORDER);	// both bad, one error
	add_retire(116, 0, 'h2010, 'h2014, 0, 'h0, 0, 'h0, 0, 'h1234, 5, VIOL_ORDER);	// x0 write
	add_retire(117, 0, 'h2014, 'h2018, 0, 'h0, 10, 'ha0, 12, 'hc0, 5, VIOL_ORDER);
	add_reset();
	add_retire(500, 0, 'h4000, 'h4004, 0, 'h0, 1, 'h999, 1, 'h1, 0, VIOL_NONE);	// x1 unknown again
	add_retire(502, 0, 'h5000, 'h5004, 1, 'h1, 0, 'h0, 2, 'h2, 2, VIOL_ORDER);	// order and pc
	add_reset();
	add_retire(7, 0, 'h100, 'h104, 0, 'h0, 0, 'h0, 1, 'h7, 0, VIOL_NONE);
	add_retire(8, 1, 'h104, 'h108, 1, 'h7, 0, 'h0, 0, 'h0, 0, VIOL_NONE);		// halts
	add_retire(9, 0, 'h108, 'h10c, 0, 'h0, 0, 'h0, 0, 'h0, 1, VIOL_AFTER_HALT);
	add_retire(3, 0, 'h10c, 'h110, 0, 'h0, 0, 'h0, 0, 'h0, 2, VIOL_AFTER_HALT);
	add_retire(10, 0, 'h110, 'h114, 0, 'h0, 0, 'h0, 0, 'h0, 3, VIOL_AFTER_HALT);
	add_reset();
endtask

`endif

// ==== dv/rvfi_monitor_tb.sv ====
module rvfi_monitor_tb import rvfi_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int XLEN				= 32;
	localparam int RESET_CYCLES		= 3;
	localparam int RESET_TIMEOUT	= 20;	// cycles
	localparam int DRIVE_DELAY		= 2;	// ns after the rising edge

	logic				clk;
	logic				rst_n;
	logic				rvfi_valid;
	logic [ORDER_W-1:0]	rvfi_order;
	logic				rvfi_halt;
	logic [XLEN-1:0]	rvfi_pc_rdata;
	logic [XLEN-1:0]	rvfi_pc_wdata;
	logic [REG_AW-1:0]	rvfi_rs1_addr;
	logic [REG_AW-1:0]	rvfi_rs2_addr;
	logic [XLEN-1:0]	rvfi_rs1_rdata;
	logic [XLEN-1:0]	rvfi_rs2_rdata;
	logic [REG_AW-1:0]	rvfi_rd_addr;
	logic [XLEN-1:0]	rvfi_rd_wdata;
	logic [CNT_W-1:0]	error_count;
	violation_code_t	first_code;
	logic				error_seen;

	int					n_checks;
	int					n_errors;
	logic [15:0]		lfsr_state;

	`include "rvfi_stim_table.svh"

	rvfi_monitor #(
		.XLEN			(XLEN)
	) i_dut (
		.clk			(clk),
		.rst_n			(rst_n),
		.rvfi_valid		(rvfi_valid),
		.rvfi_order		(rvfi_order),
		.rvfi_halt		(rvfi_halt),
		.rvfi_pc_rdata	(rvfi_pc_rdata),
		.rvfi_pc_wdata	(rvfi_pc_wdata),
		.rvfi_rs1_addr	(rvfi_rs1_addr),
		.rvfi_rs2_addr	(rvfi_rs2_addr),
		.rvfi_rs1_rdata	(rvfi_rs1_rdata),
		.rvfi_rs2_rdata	(rvfi_rs2_rdata),
		.rvfi_rd_addr	(rvfi_rd_addr),
		.rvfi_rd_wdata	(rvfi_rd_wdata),
		.error_count	(error_count),
		.first_code		(first_code),
		.error_seen		(error_seen)
	);

	always #10 clk = ~clk;	// 20 ns period

	// 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		else
			return s >> 1;
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic check_outputs(input logic [CNT_W-1:0] exp_count,
		input violation_code_t exp_code);
		check_value("error_count", exp_count, error_count);
		check_value("first_code", exp_code, first_code);
		check_value("error_seen", exp_count != 0, error_seen);	// sticky once counted
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			n_errors++;
			$display("timeout while waiting for reset release");
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		rvfi_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY rst_n = 1'b1;
		wait_reset_release();
	endtask

	task automatic drive_retire(input stim_entry_t e);
		rvfi_valid		= 1'b1;
		rvfi_order		= e.order;
		rvfi_halt		= e.halt;
		rvfi_pc_rdata	= e.pc_rdata;
		rvfi_pc_wdata	= e.pc_wdata;
		rvfi_rs1_addr	= e.rs1_addr;
		rvfi_rs2_addr	= e.rs2_addr;
		rvfi_rs1_rdata	= e.rs1_rdata;
		rvfi_rs2_rdata	= e.rs2_rdata;
		rvfi_rd_addr	= e.rd_addr;
		rvfi_rd_wdata	= e.rd_wdata;
	endtask

	initial begin
		stim_entry_t	e;
		int				idle;
		clk				= 1'b0;
		rst_n			= 1'b0;
		rvfi_valid		= 1'b0;
		rvfi_order		= '0;
		rvfi_halt		= 1'b0;
		rvfi_pc_rdata	= '0;
		rvfi_pc_wdata	= '0;
		rvfi_rs1_addr	= '0;
		rvfi_rs2_addr	= '0;
		rvfi_rs1_rdata	= '0;
		rvfi_rs2_rdata	= '0;
		rvfi_rd_addr	= '0;
		rvfi_rd_wdata	= '0;
		n_checks		= 0;
		n_errors		= 0;
		lfsr_state		= 16'd22014;
		fill_table();
		apply_reset();
		check_outputs('0, VIOL_NONE);
		foreach (stim_table[i]) begin
			e = stim_table[i];
			if (e.do_reset) begin
				apply_reset();
				check_outputs(e.exp_count, e.exp_code);
			end else begin
				take_bits(2, idle);		// 0 to 3 idle cycles
				repeat (idle) begin
					@(posedge clk);
					#DRIVE_DELAY;
				end
				drive_retire(e);
				@(posedge clk);
				#DRIVE_DELAY rvfi_valid = 1'b0;
				@(posedge clk);		// outputs settle two edges after the retirement
				#DRIVE_DELAY;
				check_outputs(e.exp_count, e.exp_code);
			end
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : rvfi_monitor_tb

// ==== rvfi_monitor.f ====
+incdir+dv
design/rvfi_pkg.sv
design/retire_order_check.sv
design/pc_chain_check.sv
design/reg_shadow_check.sv
design/violation_log.sv
design/rvfi_monitor.sv
dv/rvfi_monitor_tb.sv
